// ==== scalar_lane.f ====
pkg_tpu.sv
operand_if.sv
reg_file.sv
bypass_buff.sv
network_s.sv
scalar_alu.sv
scalar_lane.sv
tb_scalar_lane.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs one regression
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_scalar_lane -f scalar_lane.f \
	-o sim_scalar_lane > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_scalar_lane > sim.log 2>&1
cat sim.log
# The log decides the status
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_scalar_lane.sv ====
`timescale 1ns/10ps

module tb_scalar_lane
	import pkg_tpu::*;
();

	localparam int TIMEOUT_CYCLES = 20;				// Cycles without progress

	typedef struct packed {
		op_t		op;
		index_t		dst;
		index_t		src1;
		index_t		src2;
		index_t		src3;
		logic [1:0]	path;							// PAC select
		logic [1:0]	path_wb;						// Writeback move select
		index_t		slice;
		logic		stall;							// Stall in the next cycle
		logic		b2b;							// Issue right after previous row
	} row_t;

	logic		clock;
	logic		rst_n;
	logic		stall;
	logic		req;
	op_t		op;
	index_t		dst;
	index_t		src_idx1;
	index_t		src_idx2;
	index_t		src_idx3;
	logic [1:0]	sel_path;
	logic [1:0]	sel_path_wb;
	index_t		slice_len;
	logic		host_we;
	index_t		host_idx;
	data_t		host_data;
	data_t		pac_data;
	logic		wb_valid;
	index_t		wb_idx;
	data_t		wb_data;
	logic		buff_full;

	int			seed;
	row_t		rows [$];							// Stimulus table
	data_t		model [NUM_REGS];					// Reference registers
	index_t		exp_idx [$];						// Expected writebacks in order
	data_t		exp_data [$];
	data_t		exp_pac [$];
	int			exp_due [$];						// Cycle of wb_valid

	scalar_lane #(
		.NUM_REGS	(NUM_REGS),
		.BUFF_SIZE	(BYPASS_BUFF_SIZE)
	) uut (
		.clock		(clock),
		.rst_n		(rst_n),
		.stall		(stall),
		.req		(req),
		.op			(op),
		.dst		(dst),
		.src_idx1	(src_idx1),
		.src_idx2	(src_idx2),
		.src_idx3	(src_idx3),
		.sel_path	(sel_path),
		.sel_path_wb(sel_path_wb),
		.slice_len	(slice_len),
		.host_we	(host_we),
		.host_idx	(host_idx),
		.host_data	(host_data),
		.pac_data	(pac_data),
		.wb_valid	(wb_valid),
		.wb_idx		(wb_idx),
		.wb_data	(wb_data),
		.buff_full	(buff_full)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;					// 40 ns period
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Regression failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic add_row(input op_t o, input int d, input int s1, input int s2,
			input int s3, input logic [1:0] p, input logic [1:0] pw, input int sl,
			input logic st, input logic bb);
		row_t r;
		r.op		= o;
		r.dst		= index_t'(d);
		r.src1		= index_t'(s1);
		r.src2		= index_t'(s2);
		r.src3		= index_t'(s3);
		r.path		= p;
		r.path_wb	= pw;
		r.slice		= index_t'(sl);
		r.stall		= st;
		r.b2b		= bb;
		rows.push_back(r);
	endtask

	// Source value as the lane must see it
	function automatic data_t operand(input index_t idx, input index_t slice);
		return (idx < slice) ? model[idx] : '0;		// Outside slice reads zero
	endfunction

	function automatic data_t pick_path(input logic [1:0] sel, input data_t a,
			input data_t b, input data_t c, input data_t dflt);
		case (sel)
			PATH_SRC1:	return a;
			PATH_SRC2:	return b;
			PATH_SRC3:	return c;
			default:	return dflt;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Issue one row and record what it must produce

	task automatic drive_row(input row_t r);
		data_t a;
		data_t b;
		data_t c;
		data_t res;
		a = operand(r.src1, r.slice);
		b = operand(r.src2, r.slice);
		c = operand(r.src3, r.slice);
		case (r.op)
			OP_ADD:		res = a + b;
			OP_SUB:		res = a - b;
			OP_MUL:		res = a * b;					// Low word
			OP_AND:		res = a & b;
			OP_OR:		res = a | b;
			OP_XOR:		res = a ^ b;
			OP_MAC:		res = a * b + c;
			default:	res = a;
		endcase
		exp_idx.push_back(r.dst);
		exp_data.push_back(pick_path(r.path_wb, a, b, c, res));
		exp_pac.push_back(pick_path(r.path, a, b, c, '0));
		model[r.dst] = pick_path(r.path_wb, a, b, c, res);	// Program order
		req			= 1'b1;
		op			= r.op;
		dst			= r.dst;
		src_idx1	= r.src1;
		src_idx2	= r.src2;
		src_idx3	= r.src3;
		sel_path	= r.path;
		sel_path_wb	= r.path_wb;
		slice_len	= r.slice;
	endtask

	////////////////////////////////////////////////////////////
	// Apply table rows and check every writeback

	task automatic run_rows(input int first, input int last);
		int		row;
		int		cyc;
		int		quiet;
		logic	stall_next;
		data_t	last_pac;
		row = first;
		cyc = 0;
		quiet = 0;
		stall_next = 1'b0;
		last_pac = '0;
		while (row <= last || exp_data.size() > 0) begin
			@(negedge clock);
			cyc++;
			quiet++;
			if (wb_valid) begin
				if (exp_data.size() == 0) begin
					$display("Writeback seen with no instruction in flight");
					$display("Regression failed");
					$fatal(1, "stray writeback");
				end
				check_value("wb_idx", 32'(wb_idx), 32'(exp_idx.pop_front()));
				check_value("wb_data", wb_data, exp_data.pop_front());
				check_value("wb_valid cycle", 32'(cyc), 32'(exp_due.pop_front()));
				check_value("pac_data", last_pac, exp_pac.pop_front());	// Read stage
				quiet = 0;
			end else if (quiet > TIMEOUT_CYCLES) begin
				$display("No writeback arrived within %0d cycles", TIMEOUT_CYCLES);
				$display("Regression failed");
				$fatal(1, "writeback timeout");
			end
			last_pac = pac_data;
			req = 1'b0;
			stall = stall_next;
			if (stall_next) begin
				stall_next = 1'b0;
				foreach (exp_due[k]) exp_due[k] = exp_due[k] + 1;	// Whole pipe holds
			end else if (row <= last && !buff_full &&
					(exp_data.size() == 0 || rows[row].b2b)) begin
				drive_row(rows[row]);
				exp_due.push_back(cyc + 3);			// Seen at third falling edge
				stall_next = rows[row].stall;
				quiet = 0;
				row++;
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic build_table();
		add_row(OP_PASS, 1, 5, 6, 7, PATH_SRC1, PATH_NONE, 15, 0, 0);	// Zero after reset
		add_row(OP_ADD, 1, 2, 3, 4, PATH_SRC1, PATH_NONE, 15, 0, 0);	// Each opcode
		add_row(OP_SUB, 2, 5, 6, 7, PATH_SRC2, PATH_NONE, 15, 0, 0);
		add_row(OP_MUL, 3, 8, 9, 10, PATH_SRC3, PATH_NONE, 15, 0, 0);
		add_row(OP_AND, 4, 11, 12, 13, PATH_NONE, PATH_NONE, 15, 0, 0);
		add_row(OP_OR, 5, 1, 2, 3, PATH_SRC1, PATH_NONE, 15, 0, 0);
		add_row(OP_XOR, 6, 4, 5, 14, PATH_SRC2, PATH_NONE, 15, 0, 0);
		add_row(OP_MAC, 7, 6, 8, 9, PATH_SRC3, PATH_NONE, 15, 0, 0);
		add_row(OP_PASS, 8, 7, 0, 0, PATH_SRC1, PATH_NONE, 15, 0, 0);
		add_row(OP_ADD, 9, 1, 2, 0, PATH_SRC1, PATH_NONE, 15, 0, 0);		// Dependent chain
		add_row(OP_SUB, 10, 9, 3, 0, PATH_SRC1, PATH_NONE, 15, 0, 1);
		add_row(OP_MAC, 11, 10, 9, 10, PATH_SRC2, PATH_NONE, 15, 0, 1);
		add_row(OP_XOR, 9, 11, 9, 0, PATH_SRC3, PATH_NONE, 15, 0, 1);
		add_row(OP_ADD, 12, 1, 2, 3, PATH_SRC1, PATH_SRC2, 15, 0, 0);	// Source moves
		add_row(OP_MUL, 13, 4, 5, 6, PATH_SRC3, PATH_SRC3, 15, 0, 0);
		add_row(OP_OR, 14, 12, 13, 14, PATH_NONE, PATH_SRC1, 15, 0, 1);
		add_row(OP_ADD, 0, 2, 8, 12, PATH_SRC2, PATH_NONE, 8, 0, 0);		// Slice masking
		add_row(OP_MAC, 1, 0, 3, 5, PATH_SRC3, PATH_NONE, 4, 0, 0);
		add_row(OP_OR, 2, 0, 1, 2, PATH_SRC1, PATH_NONE, 0, 0, 0);
		add_row(OP_ADD, 3, 4, 5, 6, PATH_SRC1, PATH_NONE, 15, 1, 0);		// Stalled
		add_row(OP_SUB, 4, 3, 0, 1, PATH_SRC1, PATH_NONE, 15, 1, 0);
		add_row(OP_XOR, 5, 4, 3, 2, PATH_SRC2, PATH_SRC3, 15, 0, 0);
		add_row(OP_ADD, 6, 1, 2, 3, PATH_SRC1, PATH_NONE, 15, 0, 0);		// Drain blocked
		add_row(OP_SUB, 7, 6, 1, 0, PATH_SRC1, PATH_NONE, 15, 0, 0);
		add_row(OP_XOR, 6, 7, 6, 0, PATH_SRC2, PATH_NONE, 15, 0, 0);		// Second entry for 6
		add_row(OP_MAC, 8, 6, 7, 6, PATH_SRC1, PATH_NONE, 15, 0, 0);
		add_row(OP_OR, 10, 6, 7, 8, PATH_SRC3, PATH_NONE, 15, 0, 0);		// After the drain
	endtask

	initial begin
		rst_n		= 1'b0;
		stall		= 1'b0;
		req			= 1'b0;
		op			= OP_ADD;
		dst			= '0;
		src_idx1	= '0;
		src_idx2	= '0;
		src_idx3	= '0;
		sel_path	= PATH_NONE;
		sel_path_wb	= PATH_NONE;
		slice_len	= '0;
		host_we		= 1'b0;
		host_idx	= '0;
		host_data	= '0;
		seed		= 61238;
		foreach (model[k]) model[k] = '0;
		build_table();
		repeat (10) @(negedge clock);				// Reset for 10 cycles
		rst_n = 1'b1;
		@(negedge clock);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("buff_full", 32'(buff_full), 32'd0);
		run_rows(0, 0);
		idle_cycles(BYPASS_BUFF_SIZE + 2);			// Let the FIFO empty

		////////////////////////////////////////////////////////////
		// Host preload
		for (int i = 0; i < NUM_REGS; i++) begin
			@(negedge clock);
			host_we		= 1'b1;
			host_idx	= index_t'(i);
			host_data	= $random(seed);
			model[i]	= host_data;
		end
		@(negedge clock);
		host_we = 1'b0;
		run_rows(1, 21);
		idle_cycles(BYPASS_BUFF_SIZE + 2);

		// Rewrite r15 with its own value so the drain stays blocked
		@(negedge clock);
		host_we		= 1'b1;
		host_idx	= 4'd15;
		host_data	= model[15];
		run_rows(22, 25);
		@(negedge clock);							// Last entry pushed by now
		check_value("buff_full", 32'(buff_full), 32'd1);
		host_we = 1'b0;
		idle_cycles(BYPASS_BUFF_SIZE + 2);
		check_value("buff_full", 32'(buff_full), 32'd0);
		run_rows(26, 26);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== scalar_lane.sv ====
`timescale 1ns/10ps

module scalar_lane
	import pkg_tpu::*;
#(
	parameter int NUM_REGS	= pkg_tpu::NUM_REGS,
	parameter int BUFF_SIZE	= BYPASS_BUFF_SIZE
)(
	input  logic		clock,
	input  logic		rst_n,
	input  logic		stall,				// Holds every stage
	input  logic		req,				// Issue request
	input  op_t			op,
	input  index_t		dst,
	input  index_t		src_idx1,
	input  index_t		src_idx2,
	input  index_t		src_idx3,
	input  logic [1:0]	sel_path,
	input  logic [1:0]	sel_path_wb,
	input  index_t		slice_len,
	input  logic		host_we,			// Preload port
	input  index_t		host_idx,
	input  data_t		host_data,
	output data_t		pac_data,
	output logic		wb_valid,
	output index_t		wb_idx,
	output data_t		wb_data,
	output logic		buff_full
);

	logic			iss_valid;				// Issue stage
	op_t			iss_op;
	index_t			iss_dst;
	index_t			iss_idx1;
	index_t			iss_idx2;
	index_t			iss_idx3;
	logic [1:0]		iss_path;
	logic [1:0]		iss_path_wb;
	index_t			iss_slice;
	logic			rd_valid;				// Read stage
	op_t			rd_op;
	index_t			rd_dst;
	index_t			rd_idx1;
	index_t			rd_idx2;
	index_t			rd_idx3;
	logic [1:0]		rd_path;
	logic [1:0]		rd_path_wb;
	index_t			rd_slice;
	data_t			rf_data1;
	data_t			rf_data2;
	data_t			rf_data3;
	logic			drain_en;
	index_t			drain_idx;
	data_t			drain_data;

	operand_if opif ();

	////////////////////////////////////////////////////////////
	// Issue and read stage registers

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			iss_valid	<= 1'b0;
			rd_valid	<= 1'b0;
		end else if (!stall) begin
			iss_valid	<= req;
			rd_valid	<= iss_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			iss_op		<= op;
			iss_dst		<= dst;
			iss_idx1	<= src_idx1;
			iss_idx2	<= src_idx2;
			iss_idx3	<= src_idx3;
			iss_path	<= sel_path;
			iss_path_wb	<= sel_path_wb;
			iss_slice	<= slice_len;
			rd_op		<= iss_op;			// Lines up with register data
			rd_dst		<= iss_dst;
			rd_idx1		<= iss_idx1;
			rd_idx2		<= iss_idx2;
			rd_idx3		<= iss_idx3;
			rd_path		<= iss_path;
			rd_path_wb	<= iss_path_wb;
			rd_slice	<= iss_slice;
		end
	end

	reg_file #(
		.NUM_REGS	(NUM_REGS)
	) u_reg_file (
		.clock		(clock),
		.rst_n		(rst_n),
		.stall		(stall),
		.rd_idx1	(iss_idx1),
		.rd_idx2	(iss_idx2),
		.rd_idx3	(iss_idx3),
		.we			(host_we | drain_en),
		.wr_idx		(host_we ? host_idx : drain_idx),		// Host has priority
		.wr_data	(host_we ? host_data : drain_data),
		.rd_data1	(rf_data1),
		.rd_data2	(rf_data2),
		.rd_data3	(rf_data3)
	);

	network_s #(
		.NUM_LANES	(NUM_REGS),
		.BUFF_SIZE	(BUFF_SIZE)
	) u_network_s (
		.clock		(clock),
		.rst_n		(rst_n),
		.stall		(stall),
		.req_valid	(rd_valid),
		.op			(rd_op),
		.dst		(rd_dst),
		.sel_path	(rd_path),
		.sel_path_wb(rd_path_wb),
		.slice_len	(rd_slice),
		.src_idx1	(rd_idx1),
		.src_idx2	(rd_idx2),
		.src_idx3	(rd_idx3),
		.src_data1	(rf_data1),
		.src_data2	(rf_data2),
		.src_data3	(rf_data3),
		.wb_valid	(wb_valid),
		.wb_idx		(wb_idx),
		.wb_data	(wb_data),
		.drain_ready(~host_we),				// Drain waits behind host
		.pac_data	(pac_data),
		.buff_full	(buff_full),
		.drain_en	(drain_en),
		.drain_idx	(drain_idx),
		.drain_data	(drain_data),
		.opif		(opif.net)
	);

	scalar_alu u_scalar_alu (
		.clock		(clock),
		.rst_n		(rst_n),
		.stall		(stall),
		.opif		(opif.alu),
		.wb_valid	(wb_valid),
		.wb_idx		(wb_idx),
		.wb_data	(wb_data)
	);

endmodule

// ==== scalar_alu.sv ====
`timescale 1ns/10ps

module scalar_alu
	import pkg_tpu::*;
(
	input  logic	clock,
	input  logic	rst_n,
	input  logic	stall,
	operand_if.alu	opif,					// Item from operand network
	output logic	wb_valid,
	output index_t	wb_idx,
	output data_t	wb_data
);

	data_t		result;						// Opcode result
	data_t		wb_sel;						// Result or moved source

	////////////////////////////////////////////////////////////
	// Execute

	always_comb begin
		case (opif.op)
			OP_ADD:		result = opif.src1 + opif.src2;
			OP_SUB:		result = opif.src1 - opif.src2;
			OP_MUL:		result = opif.src1 * opif.src2;		// Low 32 bits
			OP_AND:		result = opif.src1 & opif.src2;
			OP_OR:		result = opif.src1 | opif.src2;
			OP_XOR:		result = opif.src1 ^ opif.src2;
			OP_MAC:		result = opif.src1 * opif.src2 + opif.src3;
			default:	result = opif.src1;					// OP_PASS
		endcase
	end

	always_comb begin						// Writeback path
		case (opif.sel_path_wb)
			PATH_SRC1:	wb_sel = opif.src1;
			PATH_SRC2:	wb_sel = opif.src2;
			PATH_SRC3:	wb_sel = opif.src3;
			default:	wb_sel = result;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Writeback register

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= opif.valid & ~stall;	// Low through a stall
		end
	end

	always_ff @(posedge clock) begin
		if (opif.valid && !stall) begin
			wb_idx	<= opif.dst;
			wb_data	<= wb_sel;
		end
	end

endmodule

// ==== network_s.sv ====
`timescale 1ns/10ps

module network_s
	import pkg_tpu::*;
#(
	parameter int NUM_LANES	= 16,
	parameter int BUFF_SIZE	= BYPASS_BUFF_SIZE
)(
	input  logic		clock,
	input  logic		rst_n,
	input  logic		stall,
	input  logic		req_valid,				// Read stage holds an instruction
	input  op_t			op,
	input  index_t		dst,
	input  logic [1:0]	sel_path,				// PAC operand select
	input  logic [1:0]	sel_path_wb,			// Writeback move select
	input  index_t		slice_len,
	input  index_t		src_idx1,
	input  index_t		src_idx2,
	input  index_t		src_idx3,
	input  data_t		src_data1,				// From register file
	input  data_t		src_data2,
	input  data_t		src_data3,
	input  logic		wb_valid,				// From ALU
	input  index_t		wb_idx,
	input  data_t		wb_data,
	input  logic		drain_ready,
	output data_t		pac_data,				// To PAC port
	output logic		buff_full,
	output logic		drain_en,
	output index_t		drain_idx,
	output data_t		drain_data,
	operand_if.net		opif
);

	data_t		fix1;						// Bypass-corrected operands
	data_t		fix2;
	data_t		fix3;
	index_t		slice_lim;

	// Slice cannot exceed the lane count
	assign slice_lim = (int'(slice_len) > NUM_LANES) ? index_t'(NUM_LANES) : slice_len;

	bypass_buff #(
		.BUFF_SIZE	(BUFF_SIZE)
	) u_bypass_buff (
		.clock		(clock),
		.rst_n		(rst_n),
		.wb_valid	(wb_valid),
		.wb_idx		(wb_idx),
		.wb_data	(wb_data),
		.slice_len	(slice_lim),
		.idx1		(src_idx1),
		.idx2		(src_idx2),
		.idx3		(src_idx3),
		.src1		(src_data1),
		.src2		(src_data2),
		.src3		(src_data3),
		.drain_ready(drain_ready),
		.out1		(fix1),
		.out2		(fix2),
		.out3		(fix3),
		.full		(buff_full),
		.drain_en	(drain_en),
		.drain_idx	(drain_idx),
		.drain_data	(drain_data)
	);

	always_comb begin						// PAC operand
		case (sel_path)
			PATH_SRC1:	pac_data = fix1;
			PATH_SRC2:	pac_data = fix2;
			PATH_SRC3:	pac_data = fix3;
			default:	pac_data = '0;
		endcase
	end

	// Operand item to ALU
	assign opif.valid		= req_valid & ~stall;
	assign opif.op			= op;
	assign opif.dst			= dst;
	assign opif.src1		= fix1;
	assign opif.src2		= fix2;
	assign opif.src3		= fix3;
	assign opif.sel_path_wb	= sel_path_wb;

endmodule

// ==== bypass_buff.sv ====
`timescale 1ns/10ps

module bypass_buff
	import pkg_tpu::*;
#(
	parameter int BUFF_SIZE = BYPASS_BUFF_SIZE
)(
	input  logic	clock,
	input  logic	rst_n,
	input  logic	wb_valid,				// Writeback from ALU
	input  index_t	wb_idx,
	input  data_t	wb_data,
	input  index_t	slice_len,				// Indexes at or above read as zero
	input  index_t	idx1,					// Source indexes
	input  index_t	idx2,
	input  index_t	idx3,
	input  data_t	src1,					// Register file values
	input  data_t	src2,
	input  data_t	src3,
	input  logic	drain_ready,			// Write port free
	output data_t	out1,					// Corrected operands
	output data_t	out2,
	output data_t	out3,
	output logic	full,
	output logic	drain_en,
	output index_t	drain_idx,
	output data_t	drain_data
);

	localparam int PTR_W = (BUFF_SIZE > 1) ? $clog2(BUFF_SIZE) : 1;
	typedef logic [PTR_W-1:0] ptr_t;

	index_t							idx_q [BUFF_SIZE];		// Entry destinations
	data_t							data_q [BUFF_SIZE];		// Entry values
	ptr_t							wr_ptr;
	ptr_t							rd_ptr;					// Oldest entry
	logic [$clog2(BUFF_SIZE+1)-1:0]	count;
	logic							push;
	logic							pop;

	function automatic ptr_t next_ptr(input ptr_t ptr);
		return (int'(ptr) == BUFF_SIZE - 1) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Newest-match lookup

	function automatic data_t lookup(input index_t idx, input data_t reg_val);
		data_t val;
		int slot;
		val = reg_val;
		for (int k = 0; k < BUFF_SIZE; k++) begin			// Oldest first so youngest wins
			slot = (int'(rd_ptr) + k) % BUFF_SIZE;
			if (k < int'(count) && idx_q[slot] == idx) begin
				val = data_q[slot];
			end
		end
		if (wb_valid && wb_idx == idx) begin				// Entry arriving this edge
			val = wb_data;
		end
		if (idx >= slice_len) begin
			val = '0;										// Outside the slice
		end
		return val;
	endfunction

	always_comb begin
		out1 = lookup(idx1, src1);
		out2 = lookup(idx2, src2);
		out3 = lookup(idx3, src3);
	end

	////////////////////////////////////////////////////////////
	// FIFO control

	assign full			= (int'(count) == BUFF_SIZE);
	assign pop			= drain_ready && (count != '0);
	assign push			= wb_valid && (!full || pop);			// Drop only on overflow
	assign drain_en		= pop;
	assign drain_idx	= idx_q[rd_ptr];
	assign drain_data	= data_q[rd_ptr];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin		// Entry payload
		if (push) begin
			idx_q[wr_ptr]	<= wb_idx;
			data_q[wr_ptr]	<= wb_data;
		end
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file
	import pkg_tpu::*;
#(
	parameter int NUM_REGS = pkg_tpu::NUM_REGS
)(
	input  logic	clock,
	input  logic	rst_n,
	input  logic	stall,					// Hold read stage
	input  index_t	rd_idx1,				// Read indexes
	input  index_t	rd_idx2,
	input  index_t	rd_idx3,
	input  logic	we,						// Host or drain write
	input  index_t	wr_idx,
	input  data_t	wr_data,
	output data_t	rd_data1,				// Valid one cycle after index
	output data_t	rd_data2,
	output data_t	rd_data3
);

	data_t			regs [NUM_REGS];		// Register array
	index_t			idx1_q;					// Latched read indexes
	index_t			idx2_q;
	index_t			idx3_q;

	////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			regs <= '{default: '0};			// Registers start at zero
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read stage

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			idx1_q <= '0;
			idx2_q <= '0;
			idx3_q <= '0;
		end else if (!stall) begin
			idx1_q <= rd_idx1;
			idx2_q <= rd_idx2;
			idx3_q <= rd_idx3;
		end
	end

	// Data follows later writes while the stage is held
	assign rd_data1 = regs[idx1_q];
	assign rd_data2 = regs[idx2_q];
	assign rd_data3 = regs[idx3_q];

endmodule

// ==== operand_if.sv ====
`timescale 1ns/10ps

// Issued operation from the operand network to the ALU
interface operand_if
	import pkg_tpu::*;
();

	logic			valid;					// Item present
	op_t			op;						// ALU opcode
	index_t			dst;					// Destination register
	data_t			src1;					// Bypass-corrected operands
	data_t			src2;
	data_t			src3;
	logic [1:0]		sel_path_wb;			// Source move select

	modport net (
		output valid,
		output op,
		output dst,
		output src1, src2, src3,
		output sel_path_wb
	);

	modport alu (
		input valid,
		input op,
		input dst,
		input src1, src2, src3,
		input sel_path_wb
	);

endinterface

// ==== pkg_tpu.sv ====
package pkg_tpu;

	////////////////////////////////////////////////////////////
	// Lane sizing

	localparam int NUM_REGS			= 16;		// Scalar register count
	localparam int BYPASS_BUFF_SIZE	= 4;		// Pending writeback depth

	////////////////////////////////////////////////////////////
	// Word and index types

	typedef logic [31:0]	data_t;				// Operand and result word
	typedef logic [3:0]		index_t;			// Register index or slice length

	// ALU opcodes
	typedef enum logic [2:0] {
		OP_ADD	= 3'h0,							// src1 + src2
		OP_SUB	= 3'h1,							// src1 - src2
		OP_MUL	= 3'h2,							// Low word of product
		OP_AND	= 3'h3,
		OP_OR	= 3'h4,
		OP_XOR	= 3'h5,
		OP_MAC	= 3'h6,							// src1 * src2 + src3
		OP_PASS	= 3'h7							// Copy of src1
	} op_t;

	// Path select codes for PAC port and writeback
	localparam logic [1:0] PATH_NONE	= 2'h0;
	localparam logic [1:0] PATH_SRC1	= 2'h1;
	localparam logic [1:0] PATH_SRC2	= 2'h2;
	localparam logic [1:0] PATH_SRC3	= 2'h3;

endpackage
